// File: compile.f
verilog/vseq_pkg.sv
verilog/vreg_scoreboard.sv
verilog/unit_tracker.sv
verilog/issue_ctrl.sv
verilog/vector_sequencer.sv
verif/vseq_chk.sv
verif/vseq_monitor.sv
verif/tb_vector_sequencer.sv

// File: run.sh
#!/bin/sh
# Build the vector sequencer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_vector_sequencer -o vsim \
  && ./obj_dir/vsim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/tb_vector_sequencer.sv
// Vector sequencer testbench

`timescale 1ns/100ps
`default_nettype none

module tb_vector_sequencer;

  import vseq_pkg::*;

  localparam int N_RANDOM  = 200;
  localparam int TOTAL_REQ = N_RANDOM + 9;
  localparam int LIMIT     = TOTAL_REQ * 40 + 200;

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        req_valid_i, req_use_vd_i, req_use_vs1_i, req_use_vs2_i, req_vm_i;
  op_e         req_op_i;
  vreg_t       req_vd_i, req_vs1_i, req_vs2_i;
  logic        req_ready_o;
  logic [7:0]  alu_done_i, mul_done_i, ld_done_i, st_done_i;
  logic        pe_req_valid_o, pe_vm_o, idle_o;
  vid_t        pe_id_o;
  op_e         pe_op_o;
  unit_e       pe_unit_o;
  vreg_t       pe_vd_o, pe_vs1_o, pe_vs2_o;
  logic [7:0]  pe_hazard_vs1_o, pe_hazard_vs2_o, pe_hazard_vm_o, pe_hazard_vd_o;
  logic [7:0]  running_o;

  integer      seed = 73517;
  logic        hold_done = 1'b0;
  logic [3:0]  release_one = '0;
  // Issued IDs per unit, oldest first
  int          unit_q [4][$];

  always #5 clk_i = ~clk_i;

  vector_sequencer i_vector_sequencer (.*);

  vseq_monitor i_vseq_monitor (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_valid_i(req_valid_i), .req_op_i(req_op_i),
    .req_vd_i(req_vd_i), .req_vs1_i(req_vs1_i), .req_vs2_i(req_vs2_i),
    .req_use_vd_i(req_use_vd_i), .req_use_vs1_i(req_use_vs1_i),
    .req_use_vs2_i(req_use_vs2_i), .req_vm_i(req_vm_i), .req_ready_i(req_ready_o),
    .alu_done_i(alu_done_i), .mul_done_i(mul_done_i), .ld_done_i(ld_done_i),
    .st_done_i(st_done_i), .pe_req_valid_i(pe_req_valid_o), .pe_id_i(pe_id_o),
    .pe_op_i(pe_op_o), .pe_unit_i(pe_unit_o), .pe_vd_i(pe_vd_o), .pe_vs1_i(pe_vs1_o),
    .pe_vs2_i(pe_vs2_o), .pe_vm_i(pe_vm_o), .pe_hazard_vs1_i(pe_hazard_vs1_o),
    .pe_hazard_vs2_i(pe_hazard_vs2_o), .pe_hazard_vm_i(pe_hazard_vm_o),
    .pe_hazard_vd_i(pe_hazard_vd_o), .running_i(running_o), .idle_i(idle_o)
  );

  bind vector_sequencer vseq_chk i_vseq_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .pe_req_valid_i(pe_req_valid_o),
    .alu_done_i(alu_done_i), .mul_done_i(mul_done_i), .ld_done_i(ld_done_i),
    .st_done_i(st_done_i), .running_i(running_o), .idle_i(idle_o)
  );

  ////////////////////////////////////////////////////////////
  // Execution unit model
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [7:0] d [4];
    for (int u = 0; u < 4; u++) d[u] = '0;
    if (pe_req_valid_o) unit_q[pe_unit_o].push_back(int'(pe_id_o));
    for (int u = 0; u < 4; u++) begin
      if (unit_q[u].size() > 0 &&
          ((!hold_done && ($random(seed) & 3) == 0) || release_one[u])) begin
        d[u][unit_q[u].pop_front()] = 1'b1;
        release_one[u] = 1'b0;
      end
    end
    alu_done_i = d[0];
    mul_done_i = d[1];
    ld_done_i  = d[2];
    st_done_i  = d[3];
  end

  // Present a request and hold it until it is taken
  task automatic send_req(op_e op);
    @(negedge clk_i);
    req_valid_i   = 1'b1;
    req_op_i      = op;
    req_vd_i      = vreg_t'($random(seed) & 3);
    req_vs1_i     = vreg_t'($random(seed) & 3);
    req_vs2_i     = vreg_t'($random(seed) & 3);
    req_use_vd_i  = ($random(seed) & 7) != 0;
    req_use_vs1_i = ($random(seed) & 7) != 0;
    req_use_vs2_i = ($random(seed) & 3) != 0;
    req_vm_i      = 1'($random(seed) & 1);
    #4;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #4;
    end
  endtask

  task automatic idle_input();
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    idle_input();
    @(negedge clk_i);
    while (!idle_o) @(negedge clk_i);
  endtask

  initial begin
    req_valid_i   = 1'b0;
    req_op_i      = VADD;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_use_vd_i  = 1'b0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    req_vm_i      = 1'b1;
    alu_done_i    = '0;
    mul_done_i    = '0;
    ld_done_i     = '0;
    st_done_i     = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    i_vseq_monitor.begin_test("reset");
    #3;
    i_vseq_monitor.check_value("req_ready_o after reset", 1, req_ready_o);
    i_vseq_monitor.check_value("idle_o after reset", 1, idle_o);
    i_vseq_monitor.check_value("pe_req_valid_o after reset", 0, pe_req_valid_o);
    i_vseq_monitor.end_test();

    i_vseq_monitor.begin_test("random");
    for (int n = 0; n < N_RANDOM; n++) begin
      if (($random(seed) & 3) == 0) idle_input();
      send_req(op_e'(3'(($random(seed) & 32'h7fff_ffff) % 7)));
    end
    wait_idle();
    i_vseq_monitor.end_test();

    // Multiplier queue fills up while completions are held off
    i_vseq_monitor.begin_test("queue_full");
    hold_done = 1'b1;
    send_req(VMUL);
    send_req(VMACC);
    @(negedge clk_i);
    req_op_i = VMUL;
    repeat (3) begin
      @(negedge clk_i);
      #4;
      i_vseq_monitor.check_value("req_ready_o with full queue", 0, req_ready_o);
    end
    release_one[UNIT_MUL] = 1'b1;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #4;
    end
    i_vseq_monitor.end_test();

    // Six more IDs join the two running multiplies
    i_vseq_monitor.begin_test("all_busy");
    repeat (4) send_req(VADD);
    repeat (2) send_req(VLE);
    idle_input();
    for (int op = 0; op < 7; op++) begin
      @(negedge clk_i);
      req_op_i = op_e'(op);
      #4;
      i_vseq_monitor.check_value("req_ready_o with all IDs busy", 0, req_ready_o);
      i_vseq_monitor.check_value("running_o with all IDs busy", 8'hff, running_o);
    end
    hold_done = 1'b0;
    wait_idle();
    i_vseq_monitor.end_test();

    i_vseq_monitor.report();
    if (i_vseq_monitor.errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (LIMIT) @(posedge clk_i);
    $display("Timeout after %0d cycles, the DUT stopped making progress", LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/vseq_monitor.sv
// Sequencer reference model and checker

`timescale 1ns/100ps
`default_nettype none

module vseq_monitor (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           req_valid_i,
  input vseq_pkg::op_e                  req_op_i,
  input vseq_pkg::vreg_t                req_vd_i,
  input vseq_pkg::vreg_t                req_vs1_i,
  input vseq_pkg::vreg_t                req_vs2_i,
  input logic                           req_use_vd_i,
  input logic                           req_use_vs1_i,
  input logic                           req_use_vs2_i,
  input logic                           req_vm_i,
  input logic                           req_ready_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  alu_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  mul_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  ld_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  st_done_i,
  input logic                           pe_req_valid_i,
  input vseq_pkg::vid_t                 pe_id_i,
  input vseq_pkg::op_e                  pe_op_i,
  input vseq_pkg::unit_e                pe_unit_i,
  input vseq_pkg::vreg_t                pe_vd_i,
  input vseq_pkg::vreg_t                pe_vs1_i,
  input vseq_pkg::vreg_t                pe_vs2_i,
  input logic                           pe_vm_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs1_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs2_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vm_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vd_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  running_i,
  input logic                           idle_i
);

  import vseq_pkg::*;

  string test_name = "none";
  int    checks = 0;
  int    errors = 0;
  int    test_errors = 0;

  // Model state, as it stands after the coming edge
  logic [7:0] run_set = '0;
  int         cnt [4];
  logic       rd_v [32];
  logic       wr_v [32];
  int         rd_id [32];
  int         wr_id [32];
  // Issue request expected in the next cycle
  logic       exp_valid = 1'b0;
  logic [31:0] exp_f [11];

  function automatic int op_unit(logic [2:0] op);
    case (op)
      3'd0, 3'd1, 3'd2: return 0;
      3'd3, 3'd4:       return 1;
      3'd5:             return 2;
      default:          return 3;
    endcase
  endfunction

  function automatic int depth_of(int u);
    case (u)
      0:       return 4;
      1:       return 2;
      default: return 3;
    endcase
  endfunction

  function automatic int lowest_free(logic [7:0] s);
    for (int i = 0; i < 8; i++) begin
      if (!s[i]) return i;
    end
    return 0;
  endfunction

  task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("Mismatch in %s: %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic begin_test(string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, test_errors);
  endtask

  task automatic report();
    $display("Summary: %0d checks, %0d errors", checks, errors);
  endtask

  task automatic reset_model();
    run_set   = '0;
    exp_valid = 1'b0;
    for (int u = 0; u < 4; u++) cnt[u] = 0;
    for (int r = 0; r < 32; r++) begin
      rd_v[r] = 1'b0;
      wr_v[r] = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One cycle of the model
  ////////////////////////////////////////////////////////////

  task automatic step();
    logic [7:0] du [4];
    logic [7:0] done;
    logic [7:0] h1, h2, hm, hd;
    logic       ready, xfer;
    int         u, nid, rid;
    du[0] = alu_done_i;
    du[1] = mul_done_i;
    du[2] = ld_done_i;
    du[3] = st_done_i;
    done  = du[0] | du[1] | du[2] | du[3];
    u     = op_unit(req_op_i);
    // No transfer while the previous issue request is out
    ready = (cnt[u] < depth_of(u)) && (run_set != 8'hff) && !exp_valid;
    check_value("req_ready_o", ready, req_ready_i);
    check_value("pe_req_valid_o", exp_valid, pe_req_valid_i);
    if (exp_valid && pe_req_valid_i) begin
      check_value("pe_id_o", exp_f[0], pe_id_i);
      check_value("pe_op_o", exp_f[1], pe_op_i);
      check_value("pe_unit_o", exp_f[2], pe_unit_i);
      check_value("pe_vd_o", exp_f[3], pe_vd_i);
      check_value("pe_vs1_o", exp_f[4], pe_vs1_i);
      check_value("pe_vs2_o", exp_f[5], pe_vs2_i);
      check_value("pe_vm_o", exp_f[6], pe_vm_i);
      check_value("pe_hazard_vs1_o", exp_f[7], pe_hazard_vs1_i);
      check_value("pe_hazard_vs2_o", exp_f[8], pe_hazard_vs2_i);
      check_value("pe_hazard_vm_o", exp_f[9], pe_hazard_vm_i);
      check_value("pe_hazard_vd_o", exp_f[10], pe_hazard_vd_i);
    end
    check_value("running_o", run_set, running_i);
    check_value("idle_o", run_set == 8'h00, idle_i);

    // Drop list entries of IDs that are gone or finishing now
    for (int r = 0; r < 32; r++) begin
      rd_v[r] = rd_v[r] && run_set[rd_id[r]] && !done[rd_id[r]];
      wr_v[r] = wr_v[r] && run_set[wr_id[r]] && !done[wr_id[r]];
    end

    xfer = req_valid_i && ready;
    nid  = lowest_free(run_set);
    if (xfer) begin
      h1 = '0;
      h2 = '0;
      hm = '0;
      hd = '0;
      // Read after write
      if (req_use_vs1_i && wr_v[req_vs1_i]) h1[wr_id[req_vs1_i]] = 1'b1;
      if (req_use_vs2_i && wr_v[req_vs2_i]) h2[wr_id[req_vs2_i]] = 1'b1;
      if (!req_vm_i && wr_v[0]) hm[wr_id[0]] = 1'b1;
      // Write after read goes to every source bitmap
      if (req_use_vd_i && rd_v[req_vd_i]) begin
        rid = rd_id[req_vd_i];
        h1[rid] = 1'b1;
        h2[rid] = 1'b1;
        hm[rid] = 1'b1;
      end
      if (req_use_vd_i && wr_v[req_vd_i]) hd[wr_id[req_vd_i]] = 1'b1;
      exp_f[0]  = nid;
      exp_f[1]  = 32'(req_op_i);
      exp_f[2]  = u;
      exp_f[3]  = 32'(req_vd_i);
      exp_f[4]  = 32'(req_vs1_i);
      exp_f[5]  = 32'(req_vs2_i);
      exp_f[6]  = 32'(req_vm_i);
      exp_f[7]  = 32'(h1);
      exp_f[8]  = 32'(h2);
      exp_f[9]  = 32'(hm);
      exp_f[10] = 32'(hd);
      // New owner of its registers
      if (req_use_vd_i) begin
        wr_v[req_vd_i]  = 1'b1;
        wr_id[req_vd_i] = nid;
      end
      if (req_use_vs1_i) begin
        rd_v[req_vs1_i]  = 1'b1;
        rd_id[req_vs1_i] = nid;
      end
      if (req_use_vs2_i) begin
        rd_v[req_vs2_i]  = 1'b1;
        rd_id[req_vs2_i] = nid;
      end
      if (!req_vm_i) begin
        rd_v[0]  = 1'b1;
        rd_id[0] = nid;
      end
    end
    exp_valid = xfer;

    // Freed IDs come back only after this edge
    run_set = run_set & ~done;
    if (xfer) run_set[nid] = 1'b1;
    for (int k = 0; k < 4; k++) begin
      if (xfer && k == u && du[k] == '0) cnt[k]++;
      else if (!(xfer && k == u) && du[k] != '0) cnt[k]--;
    end
  endtask

  // Sample between the falling edge and the next rising edge
  always begin
    @(negedge clk_i);
    #2;
    if (!rst_ni) reset_model();
    else step();
  end

endmodule

`default_nettype wire

// File: verif/vseq_chk.sv
// Sequencer protocol assertions

`timescale 1ns/100ps
`default_nettype none

module vseq_chk (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           pe_req_valid_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  alu_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  mul_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  ld_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  st_done_i,
  input logic [vseq_pkg::NR_VINSN-1:0]  running_i,
  input logic                           idle_i
);

  // Issue request is a one-cycle strobe
  a_pe_strobe : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i |=> !pe_req_valid_i)
    else $error("Issue request held high for two cycles");

  // At most one completion per unit and cycle
  a_done_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alu_done_i) && $onehot0(mul_done_i) && $onehot0(ld_done_i) && $onehot0(st_done_i))
    else $error("Done bitmap with more than one bit set");

  a_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i == (running_i == '0))
    else $error("Idle flag disagrees with running bitmap");

endmodule

`default_nettype wire

// File: verilog/vector_sequencer.sv
// Vector sequencer top level

`timescale 1ns/100ps
`default_nettype none

module vector_sequencer (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Dispatcher
  input  logic                           req_valid_i,
  input  vseq_pkg::op_e                  req_op_i,
  input  vseq_pkg::vreg_t                req_vd_i,
  input  vseq_pkg::vreg_t                req_vs1_i,
  input  vseq_pkg::vreg_t                req_vs2_i,
  input  logic                           req_use_vd_i,
  input  logic                           req_use_vs1_i,
  input  logic                           req_use_vs2_i,
  input  logic                           req_vm_i,
  output logic                           req_ready_o,
  // Completion strobes
  input  logic [vseq_pkg::NR_VINSN-1:0]  alu_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  mul_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  ld_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  st_done_i,
  // Issue request
  output logic                           pe_req_valid_o,
  output vseq_pkg::vid_t                 pe_id_o,
  output vseq_pkg::op_e                  pe_op_o,
  output vseq_pkg::unit_e                pe_unit_o,
  output vseq_pkg::vreg_t                pe_vd_o,
  output vseq_pkg::vreg_t                pe_vs1_o,
  output vseq_pkg::vreg_t                pe_vs2_o,
  output logic                           pe_vm_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs1_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs2_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vm_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vd_o,
  // Status
  output logic [vseq_pkg::NR_VINSN-1:0]  running_o,
  output logic                           idle_o
);

  import vseq_pkg::*;

  logic                accept;
  unit_e               accept_unit;
  vid_t                new_id;
  logic [NR_UNITS-1:0] unit_ready;
  vid_t                free_id;
  logic                id_avail;
  logic [NR_VINSN-1:0] done;
  logic [NR_VINSN-1:0] hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;

  // Idle when nothing is in flight
  assign idle_o = ~|running_o;

  vreg_scoreboard i_vreg_scoreboard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .new_id_i     (new_id),
    .req_vd_i     (req_vd_i),
    .req_vs1_i    (req_vs1_i),
    .req_vs2_i    (req_vs2_i),
    .req_use_vd_i (req_use_vd_i),
    .req_use_vs1_i(req_use_vs1_i),
    .req_use_vs2_i(req_use_vs2_i),
    .req_vm_i     (req_vm_i),
    .running_i    (running_o),
    .done_i       (done),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vm_o  (hazard_vm),
    .hazard_vd_o  (hazard_vd)
  );

  unit_tracker i_unit_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .accept_unit_i(accept_unit),
    .new_id_i     (new_id),
    .alu_done_i   (alu_done_i),
    .mul_done_i   (mul_done_i),
    .ld_done_i    (ld_done_i),
    .st_done_i    (st_done_i),
    .unit_ready_o (unit_ready),
    .free_id_o    (free_id),
    .id_avail_o   (id_avail),
    .running_o    (running_o),
    .done_o       (done)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_vd_i       (req_vd_i),
    .req_vs1_i      (req_vs1_i),
    .req_vs2_i      (req_vs2_i),
    .req_vm_i       (req_vm_i),
    .req_ready_o    (req_ready_o),
    .unit_ready_i   (unit_ready),
    .free_id_i      (free_id),
    .id_avail_i     (id_avail),
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vm_i    (hazard_vm),
    .hazard_vd_i    (hazard_vd),
    .accept_o       (accept),
    .accept_unit_o  (accept_unit),
    .new_id_o       (new_id),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_id_o        (pe_id_o),
    .pe_op_o        (pe_op_o),
    .pe_unit_o      (pe_unit_o),
    .pe_vd_o        (pe_vd_o),
    .pe_vs1_o       (pe_vs1_o),
    .pe_vs2_o       (pe_vs2_o),
    .pe_vm_o        (pe_vm_o),
    .pe_hazard_vs1_o(pe_hazard_vs1_o),
    .pe_hazard_vs2_o(pe_hazard_vs2_o),
    .pe_hazard_vm_o (pe_hazard_vm_o),
    .pe_hazard_vd_o (pe_hazard_vd_o)
  );

endmodule

`default_nettype wire

// File: verilog/issue_ctrl.sv
// Issue controller

`timescale 1ns/100ps
`default_nettype none

module issue_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Dispatcher
  input  logic                           req_valid_i,
  input  vseq_pkg::op_e                  req_op_i,
  input  vseq_pkg::vreg_t                req_vd_i,
  input  vseq_pkg::vreg_t                req_vs1_i,
  input  vseq_pkg::vreg_t                req_vs2_i,
  input  logic                           req_vm_i,
  output logic                           req_ready_o,
  // Unit tracker
  input  logic [vseq_pkg::NR_UNITS-1:0]  unit_ready_i,
  input  vseq_pkg::vid_t                 free_id_i,
  input  logic                           id_avail_i,
  // Scoreboard
  input  logic [vseq_pkg::NR_VINSN-1:0]  hazard_vs1_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  hazard_vs2_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  hazard_vm_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  hazard_vd_i,
  // Accept towards tracker and scoreboard
  output logic                           accept_o,
  output vseq_pkg::unit_e                accept_unit_o,
  output vseq_pkg::vid_t                 new_id_o,
  // Issue request to the execution units
  output logic                           pe_req_valid_o,
  output vseq_pkg::vid_t                 pe_id_o,
  output vseq_pkg::op_e                  pe_op_o,
  output vseq_pkg::unit_e                pe_unit_o,
  output vseq_pkg::vreg_t                pe_vd_o,
  output vseq_pkg::vreg_t                pe_vs1_o,
  output vseq_pkg::vreg_t                pe_vs2_o,
  output logic                           pe_vm_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs1_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vs2_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vm_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  pe_hazard_vd_o
);

  import vseq_pkg::*;

  ////////////////////////////////////////////////////////////
  // Accept decision
  ////////////////////////////////////////////////////////////

  unit_e target_unit;

  assign target_unit = unit_of(req_op_i);

  // Needs room in the target queue and a free ID
  // Hazards never hold the dispatcher back
  // No transfer while the previous request is on the bus
  assign req_ready_o = unit_ready_i[target_unit] & id_avail_i & ~pe_req_valid_o;

  assign accept_o      = req_valid_i & req_ready_o;
  assign accept_unit_o = target_unit;
  assign new_id_o      = free_id_i;

  ////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_req_valid_o <= 1'b0;
    end else begin
      pe_req_valid_o <= accept_o;
    end
  end

  // Request payload captured on a transfer
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      pe_id_o         <= free_id_i;
      pe_op_o         <= req_op_i;
      pe_unit_o       <= target_unit;
      pe_vd_o         <= req_vd_i;
      pe_vs1_o        <= req_vs1_i;
      pe_vs2_o        <= req_vs2_i;
      pe_vm_o         <= req_vm_i;
      pe_hazard_vs1_o <= hazard_vs1_i;
      pe_hazard_vs2_o <= hazard_vs2_i;
      pe_hazard_vm_o  <= hazard_vm_i;
      pe_hazard_vd_o  <= hazard_vd_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/unit_tracker.sv
// Execution unit tracker

`timescale 1ns/100ps
`default_nettype none

module unit_tracker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // New instruction from the issue controller
  input  logic                           accept_i,
  input  vseq_pkg::unit_e                accept_unit_i,
  input  vseq_pkg::vid_t                 new_id_i,
  // Completion strobes of the units
  input  logic [vseq_pkg::NR_VINSN-1:0]  alu_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  mul_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  ld_done_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  st_done_i,
  // Status
  output logic [vseq_pkg::NR_UNITS-1:0]  unit_ready_o,
  output vseq_pkg::vid_t                 free_id_o,
  output logic                           id_avail_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  running_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  done_o
);

  import vseq_pkg::*;

  // Done strobes indexed by unit
  logic [NR_VINSN-1:0] unit_done [NR_UNITS];

  assign unit_done[UNIT_ALU] = alu_done_i;
  assign unit_done[UNIT_MUL] = mul_done_i;
  assign unit_done[UNIT_LD]  = ld_done_i;
  assign unit_done[UNIT_ST]  = st_done_i;

  // Any ID finishing this cycle
  assign done_o = alu_done_i | mul_done_i | ld_done_i | st_done_i;

  ////////////////////////////////////////////////////////////
  // Per-unit state
  ////////////////////////////////////////////////////////////

  logic [NR_VINSN-1:0] run_q [NR_UNITS];
  logic [NR_VINSN-1:0] run_d [NR_UNITS];
  logic [CNT_W-1:0]    cnt_q [NR_UNITS];
  logic [CNT_W-1:0]    cnt_d [NR_UNITS];
  logic [NR_UNITS-1:0] cnt_up, cnt_down;

  for (genvar u = 0; u < NR_UNITS; u++) begin : g_unit
    // Count up on an accept for this unit
    assign cnt_up[u]       = accept_i & (accept_unit_i == unit_e'(u));
    // Count down on any completion of this unit
    assign cnt_down[u]     = |unit_done[u];
    // Room left in the unit queue
    assign unit_ready_o[u] = cnt_q[u] < UNIT_DEPTH[u];
  end

  always_comb begin
    for (int u = 0; u < NR_UNITS; u++) begin
      run_d[u] = run_q[u] & ~unit_done[u];
      if (cnt_up[u]) begin
        run_d[u][new_id_i] = 1'b1;
      end

      // Accept and done together cancel out
      cnt_d[u] = cnt_q[u];
      if (cnt_up[u] && !cnt_down[u]) begin
        cnt_d[u] = cnt_q[u] + CNT_W'(1);
      end else if (!cnt_up[u] && cnt_down[u]) begin
        cnt_d[u] = cnt_q[u] - CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int u = 0; u < NR_UNITS; u++) begin
        run_q[u] <= '0;
        cnt_q[u] <= '0;
      end
    end else begin
      for (int u = 0; u < NR_UNITS; u++) begin
        run_q[u] <= run_d[u];
        cnt_q[u] <= cnt_d[u];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Running set and free ID
  ////////////////////////////////////////////////////////////

  always_comb begin
    running_o = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      running_o |= run_q[u];
    end
  end

  // Lowest free ID wins, so scan from the top down
  always_comb begin
    free_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        free_id_o = vid_t'(i);
      end
    end
  end

  assign id_avail_o = ~&running_o;

endmodule

`default_nettype wire

// File: verilog/vreg_scoreboard.sv
// Vector register scoreboard

`timescale 1ns/100ps
`default_nettype none

module vreg_scoreboard (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // New instruction from the issue controller
  input  logic                           accept_i,
  input  vseq_pkg::vid_t                 new_id_i,
  input  vseq_pkg::vreg_t                req_vd_i,
  input  vseq_pkg::vreg_t                req_vs1_i,
  input  vseq_pkg::vreg_t                req_vs2_i,
  input  logic                           req_use_vd_i,
  input  logic                           req_use_vs1_i,
  input  logic                           req_use_vs2_i,
  input  logic                           req_vm_i,
  // Instruction state from the unit tracker
  input  logic [vseq_pkg::NR_VINSN-1:0]  running_i,
  input  logic [vseq_pkg::NR_VINSN-1:0]  done_i,
  // Hazard bitmaps of the incoming request
  output logic [vseq_pkg::NR_VINSN-1:0]  hazard_vs1_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  hazard_vs2_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  hazard_vm_o,
  output logic [vseq_pkg::NR_VINSN-1:0]  hazard_vd_o
);

  import vseq_pkg::*;

  ////////////////////////////////////////////////////////////
  // Reader and writer lists
  ////////////////////////////////////////////////////////////

  // Last reader and last writer of every register
  vid_t                rd_id_q [NR_VREGS];
  vid_t                wr_id_q [NR_VREGS];
  logic [NR_VREGS-1:0] rd_valid_q, rd_valid_d;
  logic [NR_VREGS-1:0] wr_valid_q, wr_valid_d;

  // Entries that still point at an instruction in flight
  logic [NR_VREGS-1:0] rd_live, wr_live;

  always_comb begin
    for (int v = 0; v < NR_VREGS; v++) begin
      // An ID finishing this cycle no longer counts
      rd_live[v] = rd_valid_q[v] & running_i[rd_id_q[v]] & ~done_i[rd_id_q[v]];
      wr_live[v] = wr_valid_q[v] & running_i[wr_id_q[v]] & ~done_i[wr_id_q[v]];
    end
  end

  ////////////////////////////////////////////////////////////
  // Hazard bitmaps
  ////////////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vm_o  = '0;
    hazard_vd_o  = '0;

    // RAW on the sources and on the mask
    if (req_use_vs1_i && wr_live[req_vs1_i]) begin
      hazard_vs1_o[wr_id_q[req_vs1_i]] = 1'b1;
    end
    if (req_use_vs2_i && wr_live[req_vs2_i]) begin
      hazard_vs2_o[wr_id_q[req_vs2_i]] = 1'b1;
    end
    if (!req_vm_i && wr_live[VMASK]) begin
      hazard_vm_o[wr_id_q[VMASK]] = 1'b1;
    end

    // WAR against the last reader of the destination
    if (req_use_vd_i && rd_live[req_vd_i]) begin
      hazard_vs1_o[rd_id_q[req_vd_i]] = 1'b1;
      hazard_vs2_o[rd_id_q[req_vd_i]] = 1'b1;
      hazard_vm_o[rd_id_q[req_vd_i]]  = 1'b1;
    end

    // WAW on the destination
    if (req_use_vd_i && wr_live[req_vd_i]) begin
      hazard_vd_o[wr_id_q[req_vd_i]] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // List update
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Drop entries of finished instructions
    rd_valid_d = rd_live;
    wr_valid_d = wr_live;

    // The accepted instruction takes over its registers
    if (accept_i) begin
      if (req_use_vd_i)  wr_valid_d[req_vd_i]  = 1'b1;
      if (req_use_vs1_i) rd_valid_d[req_vs1_i] = 1'b1;
      if (req_use_vs2_i) rd_valid_d[req_vs2_i] = 1'b1;
      if (!req_vm_i)     rd_valid_d[VMASK]     = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
      wr_valid_q <= '0;
    end else begin
      rd_valid_q <= rd_valid_d;
      wr_valid_q <= wr_valid_d;
    end
  end

  // Owner IDs of the list entries
  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (req_use_vd_i)  wr_id_q[req_vd_i]  <= new_id_i;
      if (req_use_vs1_i) rd_id_q[req_vs1_i] <= new_id_i;
      if (req_use_vs2_i) rd_id_q[req_vs2_i] <= new_id_i;
      if (!req_vm_i)     rd_id_q[VMASK]     <= new_id_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/vseq_pkg.sv
// Vector sequencer definitions

`default_nettype none

package vseq_pkg;

  ////////////////////////////////////////////////////////////
  // Instruction IDs and vector registers
  ////////////////////////////////////////////////////////////

  // Instructions that can be in flight at once
  localparam int unsigned NR_VINSN = 8;
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;

  // Architectural vector registers
  localparam int unsigned NR_VREGS = 32;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;

  // Register read by masked instructions
  localparam vreg_t VMASK = 5'd0;

  ////////////////////////////////////////////////////////////
  // Opcodes and execution units
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VMUL,
    VMACC,
    VLE,
    VSE
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LD,
    UNIT_ST
  } unit_e;

  localparam int unsigned NR_UNITS = 4;

  // Queue counter wide enough for the deepest queue
  localparam int unsigned CNT_W = 3;

  // Queue depth of each unit indexed by unit_e
  localparam logic [NR_UNITS-1:0][CNT_W-1:0] UNIT_DEPTH = {3'd3, 3'd3, 3'd2, 3'd4};

  // Unit that executes a given opcode
  function automatic unit_e unit_of(op_e op);
    unique case (op)
      VADD, VSUB, VAND: unit_of = UNIT_ALU;
      VMUL, VMACC:      unit_of = UNIT_MUL;
      VLE:              unit_of = UNIT_LD;
      default:          unit_of = UNIT_ST;
    endcase
  endfunction

endpackage

`default_nettype wire
